//--- include/alpha_cfg.svh
/*
 * timing constants for the front-end controller, in clock cycles
 * included by the RTL and the testbench
 */
`ifndef ALPHA_CFG_SVH
`define ALPHA_CFG_SVH

// time unit of the reset and trigger sequences
`define ALPHA_STEP_CYCLES 100
// extra wait for the ADC before the token goes out
`define ALPHA_ADC_CONVERSION_CYCLES 8192
// time unit of the bias shift and latch
`define ALPHA_SERIAL_STEP_CYCLES 50
// synchronizer depth ahead of the readout shift register
`define ALPHA_SYNC_STAGES 3

`endif

//--- design/alpha_bias_pkg.sv
/*
 * types for loading the chip's bias DACs over sin/sclk/pclk
 * shared by the loader, the top level and the testbench
 */
package alpha_bias_pkg;

	typedef logic [11:0] bias_value_t;
	typedef logic [1:0] bias_addr_t;
	typedef logic [15:0] bias_word_t;

	// bias register addresses, also the load order
	localparam bias_addr_t CMP = 2'd0;
	localparam bias_addr_t ISEL = 2'd1;
	localparam bias_addr_t SB = 2'd2;
	localparam bias_addr_t DB = 2'd3;

	// word as shifted out, msb first
	function automatic bias_word_t make_bias_word(input bias_addr_t addr, input bias_value_t value);
		return {2'b00, addr, value};
	endfunction

endpackage

//--- design/alpha_readout_pkg.sv
/*
 * types for the serial readout of the chip
 * shared by the deserializer, the top level and the testbench
 */
package alpha_readout_pkg;

	typedef logic [15:0] readout_word_t;
	typedef logic [3:0] nybble_t;
	typedef logic [1:0] nybble_index_t;

	// alignment pattern at the start of each packet
	localparam readout_word_t READOUT_HEADER = 16'ha1fa;

	// index 3 is the most significant nybble
	function automatic nybble_t select_nybble(input readout_word_t word, input nybble_index_t index);
		return word[{index, 2'b00} +: 4];
	endfunction

endpackage

//--- design/strobe_sequencer.sv
/*
 * two timed strobes after a start pulse, with a programmable gap in between
 * used for the chip reset (dreset, sync) and the trigger (trig_top, tok_a_in)
 */
`include "alpha_cfg.svh"

module strobe_sequencer #(
	parameter int gap_cycles = 0
) (
	input logic clock,
	input logic reset,
	input logic start,
	output logic first,
	output logic second,
	output logic busy
);

	localparam int step_cycles = `ALPHA_STEP_CYCLES;
	localparam int last_count = 5 * step_cycles + gap_cycles;
	localparam int count_width = $clog2(last_count + 1);

	localparam logic [count_width-1:0] first_on = count_width'(step_cycles);
	localparam logic [count_width-1:0] first_off = count_width'(2 * step_cycles);
	localparam logic [count_width-1:0] second_on = count_width'(3 * step_cycles + gap_cycles);
	localparam logic [count_width-1:0] second_off = count_width'(4 * step_cycles + gap_cycles);
	localparam logic [count_width-1:0] done = count_width'(last_count);

	// free running, only looked at while busy
	logic [count_width-1:0] counter;

	// counter trails the edge count by one, so first rises on edge step+1
	always_ff @(posedge clock) begin
		if (reset) begin
			counter <= '0;
			first <= 1'b0;
			second <= 1'b0;
			busy <= 1'b0;
		end else if (start) begin
			counter <= '0;
			first <= 1'b0;
			second <= 1'b0;
			busy <= 1'b1;
		end else begin
			counter <= counter + 1'b1;
			if (busy) begin
				if (counter == first_on) begin
					first <= 1'b1;
				end else if (counter == first_off) begin
					first <= 1'b0;
				end else if (counter == second_on) begin
					second <= 1'b1;
				end else if (counter == second_off) begin
					second <= 1'b0;
				end else if (counter == done) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// the chip must never see both strobes at once
	assert property (@(posedge clock) disable iff (reset) !(first && second));

endmodule

//--- design/bias_dac_loader.sv
/*
 * shifts the four bias settings into the chip, one address-tagged word each
 * every word is followed by two pclk latch pulses
 */
`include "alpha_cfg.svh"

module bias_dac_loader (
	input logic clock,
	input logic reset,
	input logic start,
	input alpha_bias_pkg::bias_value_t cmp_bias,
	input alpha_bias_pkg::bias_value_t isel_bias,
	input alpha_bias_pkg::bias_value_t sb_bias,
	input alpha_bias_pkg::bias_value_t db_bias,
	output logic sin,
	output logic sclk,
	output logic pclk,
	output logic busy
);
	import alpha_bias_pkg::*;

	localparam int slot_cycles = `ALPHA_SERIAL_STEP_CYCLES;
	localparam int slot_width = (slot_cycles > 1) ? $clog2(slot_cycles) : 1;
	localparam logic [slot_width-1:0] slot_last = slot_width'(slot_cycles - 1);

	// latch phase, in steps from the start of the word
	localparam logic [6:0] latch_sin_low = 7'd49;
	localparam logic [6:0] first_pclk_on = 7'd50;
	localparam logic [6:0] first_pclk_off = 7'd63;
	localparam logic [6:0] latch_sin_high = 7'd64;
	localparam logic [6:0] second_pclk_on = 7'd65;
	localparam logic [6:0] second_pclk_off = 7'd78;
	localparam logic [6:0] final_sin_low = 7'd79;
	localparam logic [6:0] word_end = 7'd81;

	typedef enum logic [1:0] {
		state_idle,
		state_shift,
		state_latch
	} state_t;

	state_t state;
	logic [slot_width-1:0] slot;
	logic [6:0] step;
	// 0 is the msb of the word
	logic [3:0] bit_index;
	bias_addr_t word_index;
	bias_value_t value;
	bias_word_t word;
	logic [6:0] bit_step;

	always_comb begin
		case (word_index)
			CMP: value = cmp_bias;
			ISEL: value = isel_bias;
			SB: value = sb_bias;
			default: value = db_bias;
		endcase
	end

	assign word = make_bias_word(word_index, value);
	// each bit takes three steps: data, clock high, clock low
	assign bit_step = 7'(bit_index) * 7'd3;
	assign busy = (state != state_idle);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= state_idle;
			slot <= '0;
			step <= '0;
			bit_index <= '0;
			word_index <= CMP;
			sin <= 1'b0;
			sclk <= 1'b0;
			pclk <= 1'b0;
		end else if (start) begin
			state <= state_shift;
			slot <= '0;
			step <= '0;
			bit_index <= '0;
			word_index <= CMP;
			sin <= 1'b0;
			sclk <= 1'b0;
			pclk <= 1'b0;
		end else if (state != state_idle) begin
			if (slot == slot_last) begin
				slot <= '0;
				step <= step + 7'd1;
			end else begin
				slot <= slot + 1'b1;
			end
			// events only on the first cycle of a step
			if (slot == '0) begin
				case (state)
					state_shift: begin
						if (step == bit_step + 7'd1) begin
							sin <= word[4'd15 - bit_index];
						end else if (step == bit_step + 7'd2) begin
							sclk <= 1'b1;
						end else if (step == bit_step + 7'd3) begin
							sclk <= 1'b0;
							if (bit_index == 4'd15) begin
								state <= state_latch;
							end else begin
								bit_index <= bit_index + 4'd1;
							end
						end
					end
					state_latch: begin
						case (step)
							latch_sin_low: sin <= 1'b0;
							first_pclk_on: pclk <= 1'b1;
							first_pclk_off: pclk <= 1'b0;
							latch_sin_high: sin <= 1'b1;
							second_pclk_on: pclk <= 1'b1;
							second_pclk_off: pclk <= 1'b0;
							final_sin_low: sin <= 1'b0;
							word_end: begin
								if (word_index == DB) begin
									state <= state_idle;
								end else begin
									state <= state_shift;
									word_index <= word_index + 2'd1;
									bit_index <= '0;
									step <= '0;
									slot <= '0;
								end
							end
							default: begin
							end
						endcase
					end
					default: begin
					end
				endcase
			end
		end
	end

	// shift and latch clocks must not overlap
	assert property (@(posedge clock) disable iff (reset) !(sclk && pclk));
	// data held for the whole sclk high time
	assert property (@(posedge clock) disable iff (reset) sclk |=> (!sclk || $stable(sin)));

endmodule

//--- design/readout_deserializer.sv
/*
 * deserializer for the chip's serial readout line
 * aligns on the header pattern, presents each word whole and one nybble at a time
 */
`include "alpha_cfg.svh"

module readout_deserializer (
	input logic clock,
	input logic reset,
	input logic serial_data,
	output alpha_readout_pkg::readout_word_t data_word,
	output logic header,
	output alpha_readout_pkg::nybble_t nybble,
	output alpha_readout_pkg::nybble_index_t nybble_index,
	output logic msn
);
	import alpha_readout_pkg::*;

	localparam int sync_stages = `ALPHA_SYNC_STAGES;

	logic [sync_stages-1:0] sync_sr;
	readout_word_t window;
	// bits left in the current word
	logic [3:0] bit_count;

	// line is asynchronous to the clock
	always_ff @(posedge clock) begin
		sync_sr <= {sync_sr[sync_stages-2:0], serial_data};
		window <= {window[14:0], sync_sr[sync_stages-1]};
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			bit_count <= 4'd15;
			header <= 1'b0;
			data_word <= '0;
		end else if (window == READOUT_HEADER) begin
			// realign the word boundary on the header
			bit_count <= 4'd15;
			header <= 1'b1;
			data_word <= window;
		end else if (bit_count == 4'd0) begin
			bit_count <= 4'd15;
			header <= 1'b0;
			data_word <= window;
		end else begin
			bit_count <= bit_count - 4'd1;
		end
	end

	assign nybble_index = bit_count[3:2];
	assign nybble = select_nybble(data_word, nybble_index);
	assign msn = (nybble_index == 2'd3);

	// header flag only ever accompanies a captured header word
	assert property (@(posedge clock) disable iff (reset) header |-> data_word == READOUT_HEADER);

endmodule

//--- design/alpha_control_top.sv
/*
 * controller and readout front end for the mixed-signal front-end ASIC
 * chip reset and trigger sequences, bias loading and readout deserializing
 */
`include "alpha_cfg.svh"

module alpha_control_top (
	input logic clock,
	input logic reset,
	input logic start_chip_reset,
	input logic start_trigger_sequence,
	input logic start_bias_load,
	input logic dat_a_t2f,
	input alpha_bias_pkg::bias_value_t cmp_bias,
	input alpha_bias_pkg::bias_value_t isel_bias,
	input alpha_bias_pkg::bias_value_t sb_bias,
	input alpha_bias_pkg::bias_value_t db_bias,
	output logic dreset,
	output logic sync,
	output logic trig_top,
	output logic tok_a_in,
	output logic sin,
	output logic sclk,
	output logic pclk,
	output logic reset_busy,
	output logic trigger_busy,
	output logic bias_busy,
	output alpha_readout_pkg::readout_word_t data_word,
	output logic header,
	output alpha_readout_pkg::nybble_t nybble,
	output alpha_readout_pkg::nybble_index_t nybble_index,
	output logic msn
);

	// dreset then sync, back to back
	strobe_sequencer #(
		.gap_cycles(0)
	) reset_seq (
		.clock(clock),
		.reset(reset),
		.start(start_chip_reset),
		.first(dreset),
		.second(sync),
		.busy(reset_busy)
	);

	// token waits for the ADC conversion after the trigger
	strobe_sequencer #(
		.gap_cycles(`ALPHA_ADC_CONVERSION_CYCLES)
	) trigger_seq (
		.clock(clock),
		.reset(reset),
		.start(start_trigger_sequence),
		.first(trig_top),
		.second(tok_a_in),
		.busy(trigger_busy)
	);

	bias_dac_loader bias_loader (
		.clock(clock),
		.reset(reset),
		.start(start_bias_load),
		.cmp_bias(cmp_bias),
		.isel_bias(isel_bias),
		.sb_bias(sb_bias),
		.db_bias(db_bias),
		.sin(sin),
		.sclk(sclk),
		.pclk(pclk),
		.busy(bias_busy)
	);

	readout_deserializer readout (
		.clock(clock),
		.reset(reset),
		.serial_data(dat_a_t2f),
		.data_word(data_word),
		.header(header),
		.nybble(nybble),
		.nybble_index(nybble_index),
		.msn(msn)
	);

endmodule

//--- verification/tb_clock_gen.sv
/*
 * clock and reset for the testbench
 * 10 ns clock, reset held over the first three rising edges
 */
module tb_clock_gen (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever begin
			#5 clock = ~clock;
		end
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		// released on the edge, the DUT still sees the third one
		reset <= 1'b0;
	end

endmodule

//--- verification/alpha_control_tb.sv
/*
 * testbench for the front-end controller covering pulse sequences, bias load and readout
 * stimulus and expected values come from tables applied in loops
 */
`include "alpha_cfg.svh"

module alpha_control_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import alpha_bias_pkg::*;
	import alpha_readout_pkg::*;

	localparam int step_cycles = `ALPHA_STEP_CYCLES;
	localparam int adc_cycles = `ALPHA_ADC_CONVERSION_CYCLES;
	// 82 serial steps per word
	localparam int word_cycles = 82 * `ALPHA_SERIAL_STEP_CYCLES;

	logic clock;
	logic reset;
	logic start_chip_reset;
	logic start_trigger_sequence;
	logic start_bias_load;
	logic dat_a_t2f;
	bias_value_t cmp_bias;
	bias_value_t isel_bias;
	bias_value_t sb_bias;
	bias_value_t db_bias;
	logic dreset;
	logic sync;
	logic trig_top;
	logic tok_a_in;
	logic sin;
	logic sclk;
	logic pclk;
	logic reset_busy;
	logic trigger_busy;
	logic bias_busy;
	readout_word_t data_word;
	logic header;
	nybble_t nybble;
	nybble_index_t nybble_index;
	logic msn;

	// bias settings, filled from $urandom, and the words they must produce
	bias_value_t bias_values[4];
	bias_word_t expected_words[4];
	// header first, then payload, none of it holding a1fa in any window
	readout_word_t streams[2][4] = '{
		'{16'ha1fa, 16'h1234, 16'h5678, 16'h9abc},
		'{16'ha1fa, 16'hdef0, 16'h0f0f, 16'h3c3c}
	};

	logic sclk_bits[$];
	logic pclk_sins[$];
	readout_word_t captured[$];
	logic aligned = 1'b0;
	logic sclk_prev = 1'b0;
	logic pclk_prev = 1'b0;
	logic header_prev = 1'b0;
	nybble_index_t index_prev = 2'd0;

	tb_clock_gen clock_gen (.clock(clock), .reset(reset));

	alpha_control_top dut (.*);

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_bias_word(input string name, input bias_word_t expected,
			input bias_word_t actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL time %0t %s expected %h got %h", $time, name,
					expected, actual));
	endtask

	task automatic check_readout_word(input string name, input readout_word_t expected,
			input readout_word_t actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL time %0t %s expected %h got %h", $time, name,
					expected, actual));
	endtask

	task automatic check_nybble(input string name, input nybble_t expected, input nybble_t actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL time %0t %s expected %h got %h", $time, name,
					expected, actual));
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL time %0t %s expected %b got %b", $time, name,
					expected, actual));
	endtask

	// 0 chip reset, 1 trigger, 2 bias load; called 1 ns after an edge
	task automatic pulse_start(input int which);
		case (which)
			0: start_chip_reset = 1'b1;
			1: start_trigger_sequence = 1'b1;
			default: start_bias_load = 1'b1;
		endcase
		@(posedge clock);
		#1;
		start_chip_reset = 1'b0;
		start_trigger_sequence = 1'b0;
		start_bias_load = 1'b0;
	endtask

	// k counts edges from the one that took the start strobe
	task automatic check_sequence(input int which, input int gap);
		int k;
		logic exp_first;
		logic exp_second;
		logic exp_busy;
		pulse_start(which);
		for (k = 0; k <= 5 * step_cycles + gap + 1; k++) begin
			if (k > 0) begin
				@(posedge clock);
				#1;
			end
			exp_first = (k >= step_cycles + 1) && (k < 2 * step_cycles + 1);
			exp_second = (k >= 3 * step_cycles + gap + 1) && (k < 4 * step_cycles + gap + 1);
			exp_busy = (k < 5 * step_cycles + gap + 1);
			if (which == 0) begin
				check_level("dreset", exp_first, dreset);
				check_level("sync", exp_second, sync);
				check_level("reset_busy", exp_busy, reset_busy);
			end else begin
				check_level("trig_top", exp_first, trig_top);
				check_level("tok_a_in", exp_second, tok_a_in);
				check_level("trigger_busy", exp_busy, trigger_busy);
			end
		end
	endtask

	task automatic wait_bias_idle(input int limit);
		int cycles;
		cycles = 0;
		while (bias_busy) begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > limit) abort_run("timeout waiting for bias_busy to fall");
		end
	endtask

	task automatic wait_sclk_bits(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (sclk_bits.size() < count) begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > limit) abort_run("timeout waiting for sclk edges from the bias loader");
		end
	endtask

	// msb first, as sampled on sclk rising edges
	function automatic bias_word_t collect_word(input int first_bit);
		bias_word_t word;
		int b;
		word = '0;
		for (b = 0; b < 16; b++) word = {word[14:0], sclk_bits[first_bit + b]};
		return word;
	endfunction

	task automatic load_and_check_bias();
		int w;
		int p;
		for (w = 0; w < 4; w++) begin
			bias_values[w] = bias_value_t'($urandom);
			expected_words[w] = {2'b00, bias_addr_t'(w), bias_values[w]};
		end
		cmp_bias = bias_values[CMP];
		isel_bias = bias_values[ISEL];
		sb_bias = bias_values[SB];
		db_bias = bias_values[DB];
		sclk_bits.delete();
		pclk_sins.delete();
		pulse_start(2);
		wait_bias_idle(5 * word_cycles);
		if (pclk_sins.size() != 8)
			abort_run($sformatf("FAIL time %0t pclk pulses expected 8 got %0d", $time,
					pclk_sins.size()));
		if (sclk_bits.size() != 64)
			abort_run($sformatf("FAIL time %0t sclk edges expected 64 got %0d", $time,
					sclk_bits.size()));
		for (w = 0; w < 4; w++)
			check_bias_word($sformatf("sin word %0d", w), expected_words[w], collect_word(16 * w));
		// sin low on the first latch pulse, high on the second
		for (p = 0; p < 8; p++) check_level("sin at pclk rise", (p % 2) == 1, pclk_sins[p]);
	endtask

	always @(negedge clock) begin
		if (!reset) begin
			if (sclk && pclk) abort_run("sclk and pclk were high in the same cycle");
			if (sclk && !sclk_prev) sclk_bits.push_back(sin);
			if (pclk && !pclk_prev) pclk_sins.push_back(sin);
		end
		sclk_prev = sclk;
		pclk_prev = pclk;
	end

	always @(negedge clock) begin
		if (!reset) begin
			check_nybble("nybble", data_word[4 * int'(nybble_index) +: 4], nybble);
			check_level("msn", nybble_index == 2'd3, msn);
			if (header && !header_prev) begin
				check_readout_word("data_word at header", 16'ha1fa, data_word);
				// counter reloads with the header, so the top nybble comes first
				check_level("msn at header", 1'b1, msn);
				aligned = 1'b1;
				captured.push_back(data_word);
			end else if (aligned && nybble_index == 2'd3 && index_prev == 2'd0) begin
				captured.push_back(data_word);
			end
		end
		header_prev = header;
		index_prev = nybble_index;
	end

	initial begin
		int cycles;
		int s;
		int w;
		int b;
		start_chip_reset = 1'b0;
		start_trigger_sequence = 1'b0;
		start_bias_load = 1'b0;
		dat_a_t2f = 1'b0;
		cmp_bias = '0;
		isel_bias = '0;
		sb_bias = '0;
		db_bias = '0;
		void'($urandom(23));
		@(posedge clock);
		#1;
		cycles = 0;
		while (reset) begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > 10) abort_run("timeout waiting for reset to be released");
		end
		check_level("dreset", 1'b0, dreset);
		check_level("sync", 1'b0, sync);
		check_level("trig_top", 1'b0, trig_top);
		check_level("tok_a_in", 1'b0, tok_a_in);
		check_level("sin", 1'b0, sin);
		check_level("sclk", 1'b0, sclk);
		check_level("pclk", 1'b0, pclk);
		check_level("header", 1'b0, header);
		check_level("reset_busy", 1'b0, reset_busy);
		check_level("trigger_busy", 1'b0, trigger_busy);
		check_level("bias_busy", 1'b0, bias_busy);

		check_sequence(0, 0);
		check_sequence(1, adc_cycles);
		load_and_check_bias();

		// restart a few bits into word 1
		sclk_bits.delete();
		pulse_start(2);
		wait_sclk_bits(20, 2 * word_cycles);
		pulse_start(2);
		sclk_bits.delete();
		wait_sclk_bits(16, word_cycles);
		check_bias_word("sin word after restart", expected_words[0], collect_word(0));
		wait_bias_idle(5 * word_cycles);

		for (s = 0; s < 2; s++) begin
			captured.delete();
			aligned = 1'b0;
			for (w = 0; w < 4; w++) begin
				for (b = 15; b >= 0; b--) begin
					dat_a_t2f = streams[s][w][b];
					@(posedge clock);
					#1;
				end
			end
			dat_a_t2f = 1'b0;
			cycles = 0;
			while (captured.size() < 4) begin
				@(posedge clock);
				#1;
				cycles++;
				if (cycles > 64) abort_run("timeout waiting for readout words");
			end
			for (w = 0; w < 4; w++)
				check_readout_word($sformatf("data_word %0d of stream %0d", w, s), streams[s][w],
						captured[w]);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- alpha_subsystem.f
+incdir+include
design/alpha_bias_pkg.sv
design/alpha_readout_pkg.sv
design/strobe_sequencer.sv
design/bias_dac_loader.sv
design/readout_deserializer.sv
design/alpha_control_top.sv
verification/tb_clock_gen.sv
verification/alpha_control_tb.sv
